/* filelist.f */
logic/clic_pkg.sv
logic/clic_csr_bank.sv
logic/clic_prio_select.sv
logic/clic_return_stack.sv
logic/clic_timer.sv
logic/clic_sequencer.sv
logic/clic_top.sv
tests/clic_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= clic_tb
RTL_TOP   ?= clic_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tests/clic_tb.sv */
// self-checking testbench for clic_top that compares every cycle against a reference model
module clic_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int VEC_NUM = 8;
  localparam int PRIO_WIDTH = 3;
  localparam int PC_WIDTH = 16;
  localparam int PERIOD = 40;
  localparam int DRIVE_DLY = 2;
  localparam int RAND_ITERS = 24;
  localparam int DRAIN_MAX = 64;
  localparam int WATCHDOG_CYCLES = RAND_ITERS * (2 * VEC_NUM + 4 + DRAIN_MAX) + 600;
  localparam logic [15:0] RET_PC = 16'hffff;
  localparam logic [15:0] MAIN_PC = 16'h0200;
  localparam logic [15:0] HANDLER_PC = 16'h0400;
  localparam int K_RUN = 0;
  localparam int K_TAKE = 1;
  localparam int K_CHAIN = 2;
  localparam int K_RET = 3;

  logic                clk;
  logic                reset;
  logic                csr_enable;
  clic_pkg::csr_addr_t csr_addr;
  clic_pkg::csr_op_t   csr_op;
  clic_pkg::word_t     csr_wdata;
  clic_pkg::word_t     csr_rdata;
  logic [7:0]          ext_irq;
  logic [15:0]         pc;
  clic_pkg::pc_sel_t   pc_sel;
  logic [15:0]         target_pc;
  logic                interrupt;
  logic                tail_chain;
  logic [2:0]          int_id;
  logic [2:0]          int_prio;
  logic [3:0]          level;

  // model state
  logic        m_mie;
  logic [2:0]  m_thresh;
  logic [7:0]  m_pend;
  logic [7:0]  m_en;
  logic [2:0]  m_prio [8];
  logic [13:0] m_vec [8];
  logic [15:0] stk_pc [8];
  logic [2:0]  stk_id [8];
  logic [2:0]  stk_thr [8];
  int          m_level;
  logic [2:0]  m_id;
  logic [31:0] m_count;
  logic [31:0] m_cmp;
  int          take_count;
  int          chain_count;
  int          ret_count;
  int          check_count;
  string       test_name;
  logic [15:0] lfsr;

  clic_top #(.VEC_NUM(VEC_NUM), .PRIO_WIDTH(PRIO_WIDTH), .PC_WIDTH(PC_WIDTH)) uut (
    .clk, .reset, .csr_enable_i(csr_enable), .csr_addr_i(csr_addr), .csr_op_i(csr_op),
    .csr_wdata_i(csr_wdata), .csr_rdata_o(csr_rdata), .ext_irq_i(ext_irq), .pc_i(pc),
    .pc_sel_o(pc_sel), .target_pc_o(target_pc), .interrupt_o(interrupt),
    .tail_chain_o(tail_chain), .int_id_o(int_id), .int_prio_o(int_prio), .level_o(level)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] model_read(clic_pkg::csr_addr_t a);
    logic [31:0] r;
    r = '0;
    if (a == clic_pkg::MSTATUS_ADDR) r[3] = m_mie;
    else if (a == clic_pkg::INT_THRESH_ADDR) r = 32'(m_thresh);
    else if (a == clic_pkg::STACK_DEPTH_ADDR) r = 32'(m_level);
    else if (a == clic_pkg::TIMER_COUNT_ADDR) r = m_count;
    else if (a == clic_pkg::TIMER_CMP_ADDR) r = m_cmp;
    for (int k = 0; k < VEC_NUM; k++) begin
      if (a == clic_pkg::VEC_BASE_ADDR + 12'(k)) r = 32'(m_vec[k]);
      if (a == clic_pkg::ENTRY_BASE_ADDR + 12'(k)) r = 32'({m_prio[k], m_en[k], m_pend[k]});
    end
    return r;
  endfunction

  // reference decision scanned from the top index with a strict compare
  function automatic void expect_outputs(input logic [15:0] cur_pc, output int kind,
                                         output logic [2:0] bid, output logic [2:0] bprio);
    logic found;
    found = 1'b0;
    bid = '0;
    bprio = '0;
    kind = K_RUN;
    for (int k = VEC_NUM - 1; k >= 0; k--) begin
      if (m_en[k] && m_pend[k] && m_prio[k] >= m_thresh && (!found || m_prio[k] > bprio)) begin
        found = 1'b1;
        bid = 3'(k);
        bprio = m_prio[k];
      end
    end
    if (!m_mie) kind = K_RUN;
    else if (found && bprio > m_thresh) kind = K_TAKE;
    else if (cur_pc == RET_PC && found) kind = K_CHAIN;
    else if (cur_pc == RET_PC && m_level != 0) kind = K_RET;
  endfunction

  task automatic check_value(string what, logic [31:0] exp_val, logic [31:0] act_val);
    check_count++;
    assert (exp_val === act_val) else begin
      $display("Error %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
      $display(">>> FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_and_step();
    int          kind;
    logic [2:0]  bid;
    logic [2:0]  bprio;
    logic [15:0] exp_target;
    logic [31:0] old;
    logic [31:0] wr;
    logic        match;
    logic        cmp_we;
    logic [2:0]  thr_start;
    thr_start = m_thresh;
    expect_outputs(pc, kind, bid, bprio);
    exp_target = pc;
    if (kind == K_TAKE || kind == K_CHAIN) exp_target = {m_vec[bid], 2'b00};
    if (kind == K_RET) exp_target = stk_pc[m_level-1];
    check_value("pc_sel", 32'(kind != K_RUN), 32'(pc_sel == clic_pkg::PC_INTERRUPT));
    check_value("target_pc", 32'(exp_target), 32'(target_pc));
    check_value("interrupt", 32'(kind == K_TAKE || kind == K_CHAIN), 32'(interrupt));
    check_value("tail_chain", 32'(kind == K_CHAIN), 32'(tail_chain));
    check_value("int_id", 32'(m_id), 32'(int_id));
    check_value("int_prio", 32'(m_thresh), 32'(int_prio));
    check_value("level", 32'(m_level), 32'(level));
    check_value("csr_rdata", model_read(csr_addr), csr_rdata);
    // csr write first
    old = model_read(csr_addr);
    case (csr_op)
      clic_pkg::CSR_RS: wr = old | csr_wdata;
      clic_pkg::CSR_RC: wr = old & ~csr_wdata;
      default:          wr = csr_wdata;
    endcase
    match = (m_cmp != 0) && (m_count == m_cmp);
    cmp_we = csr_enable && (csr_addr == clic_pkg::TIMER_CMP_ADDR);
    if (csr_enable) begin
      if (csr_addr == clic_pkg::MSTATUS_ADDR) m_mie = wr[3];
      if (csr_addr == clic_pkg::INT_THRESH_ADDR) m_thresh = wr[2:0];
      if (cmp_we) m_cmp = wr;
      for (int k = 0; k < VEC_NUM; k++) begin
        if (csr_addr == clic_pkg::VEC_BASE_ADDR + 12'(k)) m_vec[k] = wr[13:0];
        if (csr_addr == clic_pkg::ENTRY_BASE_ADDR + 12'(k)) begin
          m_pend[k] = wr[0];
          m_en[k] = wr[1];
          m_prio[k] = wr[4:2];
        end
      end
    end
    m_count = (match || cmp_we) ? 32'd0 : m_count + 1;
    // hardware pends before the sequencer's effects
    m_pend[0] = m_pend[0] | match;
    for (int k = 1; k < VEC_NUM; k++) m_pend[k] = m_pend[k] | ext_irq[k];
    if (kind == K_TAKE) begin
      stk_pc[m_level] = pc;
      stk_id[m_level] = m_id;
      stk_thr[m_level] = thr_start;
      m_level++;
      take_count++;
    end
    if (kind == K_TAKE || kind == K_CHAIN) begin
      if (kind == K_CHAIN) chain_count++;
      m_thresh = bprio;
      m_pend[bid] = 1'b0;
      m_id = bid;
    end else if (kind == K_RET) begin
      m_level--;
      m_thresh = stk_thr[m_level];
      m_id = stk_id[m_level];
      ret_count++;
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      #(PERIOD - DRIVE_DLY);
      if (!reset) begin
        check_and_step();
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("watchdog timeout: the test sequence did not finish in time");
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic csr_write(clic_pkg::csr_addr_t a, clic_pkg::csr_op_t op, logic [31:0] d);
    csr_enable = 1'b1;
    csr_addr = a;
    csr_op = op;
    csr_wdata = d;
    next_cycle();
    csr_enable = 1'b0;
  endtask

  task automatic csr_read(clic_pkg::csr_addr_t a);
    csr_enable = 1'b0;
    csr_addr = a;
    next_cycle();
  endtask

  function automatic int event_count(int kind);
    if (kind == K_TAKE) return take_count;
    if (kind == K_CHAIN) return chain_count;
    return ret_count;
  endfunction

  task automatic wait_for(int kind, int limit);
    int start;
    start = event_count(kind);
    for (int i = 0; i < limit; i++) begin
      next_cycle();
      if (event_count(kind) != start) return;
    end
    $display("%s: expected interrupt event %0d did not happen", test_name, kind);
    $display(">>> FAIL");
    $fatal(1, "event timeout");
  endtask

  // return until the stack is empty and nothing qualifies
  task automatic drain();
    int          kind;
    logic [2:0]  bid;
    logic [2:0]  bprio;
    pc = RET_PC;
    for (int i = 0; i < DRAIN_MAX; i++) begin
      next_cycle();
      expect_outputs(RET_PC, kind, bid, bprio);
      if (m_level == 0 && kind == K_RUN) begin
        pc = MAIN_PC;
        return;
      end
    end
    $display("%s: handlers did not unwind", test_name);
    $display(">>> FAIL");
    $fatal(1, "drain timeout");
  endtask

  task automatic pulse_irq(int k);
    ext_irq = 8'(1 << k);
    next_cycle();
    ext_irq = '0;
  endtask

  task automatic csr_tests();
    test_name = "csr_access";
    csr_write(clic_pkg::INT_THRESH_ADDR, clic_pkg::CSR_RW, 5);
    csr_read(clic_pkg::INT_THRESH_ADDR);
    csr_write(clic_pkg::INT_THRESH_ADDR, clic_pkg::CSR_RS, 2);
    csr_read(clic_pkg::INT_THRESH_ADDR);
    csr_write(clic_pkg::INT_THRESH_ADDR, clic_pkg::CSR_RC, 4);
    csr_read(clic_pkg::INT_THRESH_ADDR);
    csr_write(clic_pkg::INT_THRESH_ADDR, clic_pkg::CSR_RW, 0);
    for (int k = 0; k < VEC_NUM; k++) begin
      csr_write(clic_pkg::VEC_BASE_ADDR + 12'(k), clic_pkg::CSR_RW, 32'h100 + 32'(k * 16));
      csr_read(clic_pkg::VEC_BASE_ADDR + 12'(k));
    end
    csr_write(clic_pkg::VEC_BASE_ADDR + 12'd2, clic_pkg::CSR_RS, 32'h3);
    csr_write(clic_pkg::VEC_BASE_ADDR + 12'd2, clic_pkg::CSR_RC, 32'h1);
    csr_read(clic_pkg::VEC_BASE_ADDR + 12'd2);
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd3, clic_pkg::CSR_RW, 32'h1a);
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd3, clic_pkg::CSR_RS, 32'h1);
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd3, clic_pkg::CSR_RC, 32'h2);
    csr_read(clic_pkg::ENTRY_BASE_ADDR + 12'd3);
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd3, clic_pkg::CSR_RW, 0);
    csr_read(12'h123);
    csr_read(clic_pkg::VEC_BASE_ADDR + 12'(VEC_NUM));
    csr_write(clic_pkg::STACK_DEPTH_ADDR, clic_pkg::CSR_RW, 32'hff);
    csr_read(clic_pkg::STACK_DEPTH_ADDR);
    csr_write(clic_pkg::TIMER_COUNT_ADDR, clic_pkg::CSR_RW, 32'h55);
    csr_read(clic_pkg::TIMER_COUNT_ADDR);
    csr_write(clic_pkg::MSTATUS_ADDR, clic_pkg::CSR_RS, 32'h8);
    csr_read(clic_pkg::MSTATUS_ADDR);
    csr_write(clic_pkg::MSTATUS_ADDR, clic_pkg::CSR_RC, 32'h8);
  endtask

  task automatic priority_tests();
    test_name = "priority_select";
    for (int it = 0; it < RAND_ITERS; it++) begin
      csr_write(clic_pkg::MSTATUS_ADDR, clic_pkg::CSR_RW, rand_bits(1) << 3);
      csr_write(clic_pkg::INT_THRESH_ADDR, clic_pkg::CSR_RW, rand_bits(2));
      for (int k = 0; k < VEC_NUM; k++) begin
        ext_irq = 8'(rand_bits(8));
        csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'(k), clic_pkg::CSR_RW, rand_bits(5));
      end
      ext_irq = '0;
      csr_write(clic_pkg::MSTATUS_ADDR, clic_pkg::CSR_RS, 32'h8);
      drain();
    end
    csr_write(clic_pkg::MSTATUS_ADDR, clic_pkg::CSR_RW, 0);
    csr_write(clic_pkg::INT_THRESH_ADDR, clic_pkg::CSR_RW, 0);
    for (int k = 0; k < VEC_NUM; k++) begin
      csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'(k), clic_pkg::CSR_RW, 0);
    end
  endtask

  task automatic nesting_test();
    test_name = "nesting";
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd2, clic_pkg::CSR_RW, 32'ha);
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd5, clic_pkg::CSR_RW, 32'h16);
    csr_write(clic_pkg::MSTATUS_ADDR, clic_pkg::CSR_RW, 32'h8);
    pulse_irq(2);
    wait_for(K_TAKE, 4);
    check_value("first id", 2, 32'(int_id));
    pc = HANDLER_PC;
    pulse_irq(5);
    wait_for(K_TAKE, 4);
    check_value("second id", 5, 32'(int_id));
    check_value("nest level", 2, 32'(level));
    pc = HANDLER_PC + 16'h80;
    next_cycle();
    pc = RET_PC;
    wait_for(K_RET, 2);
    check_value("level after return", 1, 32'(level));
    check_value("id after return", 2, 32'(int_id));
    check_value("prio after return", 2, 32'(int_prio));
    pc = HANDLER_PC;
    next_cycle();
    pc = RET_PC;
    wait_for(K_RET, 2);
    check_value("level at base", 0, 32'(level));
    pc = MAIN_PC;
    next_cycle();
  endtask

  task automatic tail_chain_test();
    test_name = "tail_chain";
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd4, clic_pkg::CSR_RW, 32'h12);
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd3, clic_pkg::CSR_RW, 32'h12);
    pulse_irq(4);
    wait_for(K_TAKE, 4);
    pc = HANDLER_PC;
    pulse_irq(3);
    next_cycle();
    pc = RET_PC;
    wait_for(K_CHAIN, 2);
    check_value("chained id", 3, 32'(int_id));
    check_value("chain level", 1, 32'(level));
    pc = HANDLER_PC;
    next_cycle();
    pc = RET_PC;
    wait_for(K_RET, 2);
    pc = MAIN_PC;
    next_cycle();
  endtask

  task automatic timer_test();
    test_name = "timer";
    csr_write(clic_pkg::ENTRY_BASE_ADDR + 12'd0, clic_pkg::CSR_RW, 32'h1a);
    csr_write(clic_pkg::TIMER_CMP_ADDR, clic_pkg::CSR_RW, 10);
    wait_for(K_TAKE, 20);
    check_value("timer id", 0, 32'(int_id));
    check_value("timer prio", 6, 32'(int_prio));
    pc = HANDLER_PC;
    csr_write(clic_pkg::TIMER_CMP_ADDR, clic_pkg::CSR_RW, 0);
    pc = RET_PC;
    wait_for(K_RET, 2);
    pc = MAIN_PC;
    next_cycle();
  endtask

  initial begin
    reset = 1'b1;
    csr_enable = 1'b0;
    csr_addr = '0;
    csr_op = clic_pkg::CSR_RW;
    csr_wdata = '0;
    ext_irq = '0;
    pc = MAIN_PC;
    lfsr = 16'd42070;
    test_name = "reset";
    m_mie = 1'b0;
    m_thresh = '0;
    m_pend = '0;
    m_en = '0;
    m_level = 0;
    m_id = '0;
    m_count = '0;
    m_cmp = '0;
    take_count = 0;
    chain_count = 0;
    ret_count = 0;
    check_count = 0;
    for (int k = 0; k < VEC_NUM; k++) begin
      m_prio[k] = '0;
      m_vec[k] = '0;
    end
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;
    csr_tests();
    priority_tests();
    nesting_test();
    tail_chain_test();
    timer_test();
    if (check_count > 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("no output was ever compared");
      $display(">>> FAIL");
      $fatal(1, "no checks");
    end
  end

endmodule

/* logic/clic_top.sv */
// CLIC top level, wires the register bank, selector, sequencer, return stack and timer
module clic_top #(
  parameter int VEC_NUM    = 8,
  parameter int PRIO_WIDTH = 3,
  parameter int PC_WIDTH   = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         csr_enable_i,
  input  clic_pkg::csr_addr_t          csr_addr_i,
  input  clic_pkg::csr_op_t            csr_op_i,
  input  clic_pkg::word_t              csr_wdata_i,
  output clic_pkg::word_t              csr_rdata_o,
  input  logic [VEC_NUM-1:0]           ext_irq_i,
  input  logic [PC_WIDTH-1:0]          pc_i,
  output clic_pkg::pc_sel_t            pc_sel_o,
  output logic [PC_WIDTH-1:0]          target_pc_o,
  output logic                         interrupt_o,
  output logic                         tail_chain_o,
  output logic [$clog2(VEC_NUM)-1:0]   int_id_o,
  output logic [PRIO_WIDTH-1:0]        int_prio_o,
  output logic [PRIO_WIDTH:0]          level_o
);
  localparam int ID_W    = $clog2(VEC_NUM);
  localparam int STACK_W = PC_WIDTH + ID_W + PRIO_WIDTH;

  clic_pkg::word_t              timer_rdata;
  logic                         timer_pend;
  logic                         mie;
  logic [PRIO_WIDTH-1:0]        thresh;
  logic [VEC_NUM-1:0]           entry_pend;
  logic [VEC_NUM-1:0]           entry_en;
  logic [VEC_NUM*PRIO_WIDTH-1:0] entry_prio;
  logic [VEC_NUM*(PC_WIDTH-2)-1:0] vec_addr;
  logic                         best_valid;
  logic [ID_W-1:0]              best_id;
  logic [PRIO_WIDTH-1:0]        best_prio;
  logic [PC_WIDTH-3:0]          best_vec;
  logic                         thresh_we;
  logic [PRIO_WIDTH-1:0]        thresh_wdata;
  logic                         clear_pend_valid;
  logic [ID_W-1:0]              clear_pend_id;
  logic                         push;
  logic                         pop;
  logic [STACK_W-1:0]           push_data;
  logic [STACK_W-1:0]           stack_top;

  clic_csr_bank #(.VEC_NUM(VEC_NUM), .PRIO_WIDTH(PRIO_WIDTH), .PC_WIDTH(PC_WIDTH)) u_bank (
    .clk, .reset, .csr_enable_i, .csr_addr_i, .csr_op_i, .csr_wdata_i,
    .timer_rdata_i(timer_rdata), .level_i(level_o), .timer_pend_i(timer_pend), .ext_irq_i,
    .thresh_we_i(thresh_we), .thresh_wdata_i(thresh_wdata),
    .clear_pend_valid_i(clear_pend_valid), .clear_pend_id_i(clear_pend_id),
    .csr_rdata_o, .mie_o(mie), .thresh_o(thresh), .entry_pend_o(entry_pend),
    .entry_en_o(entry_en), .entry_prio_o(entry_prio), .vec_addr_o(vec_addr)
  );

  clic_prio_select #(.VEC_NUM(VEC_NUM), .PRIO_WIDTH(PRIO_WIDTH), .PC_WIDTH(PC_WIDTH)) u_select (
    .entry_pend_i(entry_pend), .entry_en_i(entry_en), .entry_prio_i(entry_prio),
    .vec_addr_i(vec_addr), .thresh_i(thresh), .best_valid_o(best_valid),
    .best_id_o(best_id), .best_prio_o(best_prio), .best_vec_o(best_vec)
  );

  clic_sequencer #(.VEC_NUM(VEC_NUM), .PRIO_WIDTH(PRIO_WIDTH), .PC_WIDTH(PC_WIDTH)) u_seq (
    .clk, .reset, .pc_i, .mie_i(mie), .thresh_i(thresh), .best_valid_i(best_valid),
    .best_id_i(best_id), .best_prio_i(best_prio), .best_vec_i(best_vec),
    .stack_data_i(stack_top), .level_i(level_o), .stack_data_o(push_data),
    .push_o(push), .pop_o(pop), .thresh_we_o(thresh_we), .thresh_wdata_o(thresh_wdata),
    .clear_pend_valid_o(clear_pend_valid), .clear_pend_id_o(clear_pend_id),
    .pc_sel_o, .target_pc_o, .interrupt_o, .tail_chain_o, .int_id_o, .int_prio_o
  );

  // one stack slot per priority level
  clic_return_stack #(.DEPTH(2 ** PRIO_WIDTH), .WIDTH(STACK_W)) u_stack (
    .clk, .reset, .push_i(push), .pop_i(pop), .data_i(push_data),
    .data_o(stack_top), .level_o
  );

  clic_timer u_timer (
    .clk, .reset, .csr_enable_i, .csr_addr_i, .csr_op_i, .csr_wdata_i,
    .timer_rdata_o(timer_rdata), .timer_pend_o(timer_pend)
  );

endmodule

/* logic/clic_sequencer.sv */
// interrupt decision logic: take, tail-chain, return or run, and the current interrupt id
module clic_sequencer #(
  parameter int VEC_NUM    = 8,
  parameter int PRIO_WIDTH = 3,
  parameter int PC_WIDTH   = 16
) (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic [PC_WIDTH-1:0]                           pc_i,
  input  logic                                          mie_i,
  input  logic [PRIO_WIDTH-1:0]                         thresh_i,
  input  logic                                          best_valid_i,
  input  logic [$clog2(VEC_NUM)-1:0]                    best_id_i,
  input  logic [PRIO_WIDTH-1:0]                         best_prio_i,
  input  logic [PC_WIDTH-3:0]                           best_vec_i,
  input  logic [PC_WIDTH+$clog2(VEC_NUM)+PRIO_WIDTH-1:0] stack_data_i,
  input  logic [PRIO_WIDTH:0]                           level_i,
  output logic [PC_WIDTH+$clog2(VEC_NUM)+PRIO_WIDTH-1:0] stack_data_o,
  output logic                                          push_o,
  output logic                                          pop_o,
  output logic                                          thresh_we_o,
  output logic [PRIO_WIDTH-1:0]                         thresh_wdata_o,
  output logic                                          clear_pend_valid_o,
  output logic [$clog2(VEC_NUM)-1:0]                    clear_pend_id_o,
  output clic_pkg::pc_sel_t                             pc_sel_o,
  output logic [PC_WIDTH-1:0]                           target_pc_o,
  output logic                                          interrupt_o,
  output logic                                          tail_chain_o,
  output logic [$clog2(VEC_NUM)-1:0]                    int_id_o,
  output logic [PRIO_WIDTH-1:0]                         int_prio_o
);
  localparam int ID_W = $clog2(VEC_NUM);
  // handlers jump here to return
  localparam logic [PC_WIDTH-1:0] RET_PC = '1;

  logic [ID_W-1:0]       id_q, id_d;
  logic [PC_WIDTH-1:0]   stk_pc;
  logic [ID_W-1:0]       stk_id;
  logic [PRIO_WIDTH-1:0] stk_thresh;
  logic                  at_return;
  logic                  take;
  logic                  chain;

  assign {stk_pc, stk_id, stk_thresh} = stack_data_i;
  assign stack_data_o = {pc_i, id_q, thresh_i};

  assign at_return = (pc_i == RET_PC);
  assign take      = mie_i && best_valid_i && (best_prio_i > thresh_i);
  assign chain     = mie_i && !take && at_return && best_valid_i;

  always_comb begin
    push_o             = 1'b0;
    pop_o              = 1'b0;
    thresh_we_o        = 1'b0;
    thresh_wdata_o     = best_prio_i;
    clear_pend_valid_o = 1'b0;
    clear_pend_id_o    = best_id_i;
    pc_sel_o           = clic_pkg::PC_NORMAL;
    target_pc_o        = pc_i;
    interrupt_o        = 1'b0;
    tail_chain_o       = 1'b0;
    id_d               = id_q;
    if (take || chain) begin
      // chain reuses the stacked context of the handler just finished
      push_o             = take;
      tail_chain_o       = chain;
      thresh_we_o        = 1'b1;
      clear_pend_valid_o = 1'b1;
      pc_sel_o           = clic_pkg::PC_INTERRUPT;
      target_pc_o        = {best_vec_i, 2'b00};
      interrupt_o        = 1'b1;
      id_d               = best_id_i;
    end else if (mie_i && at_return && level_i != '0) begin
      pop_o          = 1'b1;
      thresh_we_o    = 1'b1;
      thresh_wdata_o = stk_thresh;
      pc_sel_o       = clic_pkg::PC_INTERRUPT;
      target_pc_o    = stk_pc;
      id_d           = stk_id;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_q <= '0;
    end else begin
      id_q <= id_d;
    end
  end

  assign int_id_o   = id_q;
  assign int_prio_o = thresh_i;

endmodule

/* logic/clic_timer.sv */
// free-running timer with a csr compare register, pulses the pend request of entry 0 on a match
module clic_timer (
  input  logic                clk,
  input  logic                reset,
  input  logic                csr_enable_i,
  input  clic_pkg::csr_addr_t csr_addr_i,
  input  clic_pkg::csr_op_t   csr_op_i,
  input  clic_pkg::word_t     csr_wdata_i,
  output clic_pkg::word_t     timer_rdata_o,
  output logic                timer_pend_o
);
  clic_pkg::word_t count_q;
  clic_pkg::word_t cmp_q;
  logic            cmp_we;
  logic            match;

  assign cmp_we = csr_enable_i && (csr_addr_i == clic_pkg::TIMER_CMP_ADDR);
  // compare of zero means the timer is off
  assign match  = (cmp_q != '0) && (count_q == cmp_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
      cmp_q   <= '0;
    end else begin
      // new compare value restarts the period
      if (match || cmp_we) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
      if (cmp_we) begin
        cmp_q <= clic_pkg::csr_apply(cmp_q, csr_wdata_i, csr_op_i);
      end
    end
  end

  // counter address is read-only, writes to it fall through
  always_comb begin
    timer_rdata_o = '0;
    if (csr_addr_i == clic_pkg::TIMER_COUNT_ADDR) begin
      timer_rdata_o = count_q;
    end else if (csr_addr_i == clic_pkg::TIMER_CMP_ADDR) begin
      timer_rdata_o = cmp_q;
    end
  end

  assign timer_pend_o = match;

endmodule

/* logic/clic_return_stack.sv */
// LIFO of interrupt context words for nested handlers, top entry visible combinationally
module clic_return_stack #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 22
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push_i,
  input  logic                   pop_i,
  input  logic [WIDTH-1:0]       data_i,
  output logic [WIDTH-1:0]       data_o,
  output logic [$clog2(DEPTH):0] level_o
);
  localparam int IDX_W = $clog2(DEPTH);

  logic [WIDTH-1:0]   mem [DEPTH];
  logic [IDX_W:0]     level_q;
  logic [IDX_W-1:0]   top_idx;

  // level counts entries, the top sits one below it
  assign top_idx = level_q[IDX_W-1:0] - 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      level_q <= '0;
    end else if (push_i) begin
      level_q <= level_q + 1'b1;
    end else if (pop_i) begin
      level_q <= level_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[level_q[IDX_W-1:0]] <= data_i;
    end
  end

  assign data_o  = mem[top_idx];
  assign level_o = level_q;

  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    push_i |-> (int'(level_q) < DEPTH));
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop_i |-> (level_q != '0));
  a_push_pop_excl: assert property (@(posedge clk) disable iff (reset)
    !(push_i && pop_i));

endmodule

/* logic/clic_prio_select.sv */
// combinational search for the highest-priority enabled, pended entry at or above the threshold
module clic_prio_select #(
  parameter int VEC_NUM    = 8,
  parameter int PRIO_WIDTH = 3,
  parameter int PC_WIDTH   = 16
) (
  input  logic [VEC_NUM-1:0]              entry_pend_i,
  input  logic [VEC_NUM-1:0]              entry_en_i,
  input  logic [VEC_NUM*PRIO_WIDTH-1:0]   entry_prio_i,
  input  logic [VEC_NUM*(PC_WIDTH-2)-1:0] vec_addr_i,
  input  logic [PRIO_WIDTH-1:0]           thresh_i,
  output logic                            best_valid_o,
  output logic [$clog2(VEC_NUM)-1:0]      best_id_o,
  output logic [PRIO_WIDTH-1:0]           best_prio_o,
  output logic [PC_WIDTH-3:0]             best_vec_o
);
  localparam int ID_W  = $clog2(VEC_NUM);
  localparam int VEC_W = PC_WIDTH - 2;

  // ascending scan with >=, so the higher index wins a tie
  always_comb begin
    best_valid_o = 1'b0;
    best_id_o    = '0;
    best_prio_o  = '0;
    best_vec_o   = '0;
    for (int k = 0; k < VEC_NUM; k++) begin
      if (entry_en_i[k] && entry_pend_i[k] &&
          entry_prio_i[k*PRIO_WIDTH +: PRIO_WIDTH] >= thresh_i &&
          (!best_valid_o || entry_prio_i[k*PRIO_WIDTH +: PRIO_WIDTH] >= best_prio_o)) begin
        best_valid_o = 1'b1;
        best_id_o    = ID_W'(k);
        best_prio_o  = entry_prio_i[k*PRIO_WIDTH +: PRIO_WIDTH];
        best_vec_o   = vec_addr_i[k*VEC_W +: VEC_W];
      end
    end
  end

endmodule

/* logic/clic_csr_bank.sv */
// CLIC register file: entries, vectors, threshold and mstatus, with hardware updates and csr read mux
module clic_csr_bank #(
  parameter int VEC_NUM    = 8,
  parameter int PRIO_WIDTH = 3,
  parameter int PC_WIDTH   = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            csr_enable_i,
  input  clic_pkg::csr_addr_t             csr_addr_i,
  input  clic_pkg::csr_op_t               csr_op_i,
  input  clic_pkg::word_t                 csr_wdata_i,
  input  clic_pkg::word_t                 timer_rdata_i,
  input  logic [PRIO_WIDTH:0]             level_i,
  input  logic                            timer_pend_i,
  input  logic [VEC_NUM-1:0]              ext_irq_i,
  input  logic                            thresh_we_i,
  input  logic [PRIO_WIDTH-1:0]           thresh_wdata_i,
  input  logic                            clear_pend_valid_i,
  input  logic [$clog2(VEC_NUM)-1:0]      clear_pend_id_i,
  output clic_pkg::word_t                 csr_rdata_o,
  output logic                            mie_o,
  output logic [PRIO_WIDTH-1:0]           thresh_o,
  output logic [VEC_NUM-1:0]              entry_pend_o,
  output logic [VEC_NUM-1:0]              entry_en_o,
  output logic [VEC_NUM*PRIO_WIDTH-1:0]   entry_prio_o,
  output logic [VEC_NUM*(PC_WIDTH-2)-1:0] vec_addr_o
);
  // vectors are word addresses
  localparam int VEC_W = PC_WIDTH - 2;

  logic                               mie_q, mie_d;
  logic [PRIO_WIDTH-1:0]              thresh_q, thresh_d;
  logic [VEC_NUM-1:0]                 pend_q, pend_d;
  logic [VEC_NUM-1:0]                 en_q, en_d;
  logic [VEC_NUM-1:0][PRIO_WIDTH-1:0] prio_q, prio_d;
  logic [VEC_NUM-1:0][VEC_W-1:0]      vec_q, vec_d;
  clic_pkg::word_t                    reg_rdata;
  clic_pkg::word_t                    wr_word;

  // old value of the addressed register, also the base for set/clear ops
  always_comb begin
    reg_rdata = '0;
    if (csr_addr_i == clic_pkg::MSTATUS_ADDR) begin
      reg_rdata[clic_pkg::MIE_BIT] = mie_q;
    end else if (csr_addr_i == clic_pkg::INT_THRESH_ADDR) begin
      reg_rdata = clic_pkg::word_t'(thresh_q);
    end else if (csr_addr_i == clic_pkg::STACK_DEPTH_ADDR) begin
      reg_rdata = clic_pkg::word_t'(level_i);
    end
    for (int k = 0; k < VEC_NUM; k++) begin
      if (csr_addr_i == clic_pkg::VEC_BASE_ADDR + clic_pkg::csr_addr_t'(k)) begin
        reg_rdata = clic_pkg::word_t'(vec_q[k]);
      end
      if (csr_addr_i == clic_pkg::ENTRY_BASE_ADDR + clic_pkg::csr_addr_t'(k)) begin
        reg_rdata = clic_pkg::word_t'({prio_q[k], en_q[k], pend_q[k]});
      end
    end
  end

  assign csr_rdata_o = reg_rdata | timer_rdata_i;
  assign wr_word     = clic_pkg::csr_apply(reg_rdata, csr_wdata_i, csr_op_i);

  always_comb begin
    mie_d    = mie_q;
    thresh_d = thresh_q;
    pend_d   = pend_q;
    en_d     = en_q;
    prio_d   = prio_q;
    vec_d    = vec_q;
    // stack depth is read-only, so no write decode for it
    if (csr_enable_i) begin
      if (csr_addr_i == clic_pkg::MSTATUS_ADDR) begin
        mie_d = wr_word[clic_pkg::MIE_BIT];
      end
      if (csr_addr_i == clic_pkg::INT_THRESH_ADDR) begin
        thresh_d = wr_word[PRIO_WIDTH-1:0];
      end
      for (int k = 0; k < VEC_NUM; k++) begin
        if (csr_addr_i == clic_pkg::VEC_BASE_ADDR + clic_pkg::csr_addr_t'(k)) begin
          vec_d[k] = wr_word[VEC_W-1:0];
        end
        if (csr_addr_i == clic_pkg::ENTRY_BASE_ADDR + clic_pkg::csr_addr_t'(k)) begin
          pend_d[k] = wr_word[clic_pkg::ENTRY_PEND_BIT];
          en_d[k]   = wr_word[clic_pkg::ENTRY_EN_BIT];
          prio_d[k] = wr_word[clic_pkg::ENTRY_EN_BIT+1 +: PRIO_WIDTH];
        end
      end
    end
    // hw pend sets after the csr write, entry 0 belongs to the timer
    pend_d[0]           = pend_d[0] | timer_pend_i;
    pend_d[VEC_NUM-1:1] = pend_d[VEC_NUM-1:1] | ext_irq_i[VEC_NUM-1:1];
    // sequencer clear and threshold update win over everything
    if (clear_pend_valid_i) begin
      pend_d[clear_pend_id_i] = 1'b0;
    end
    if (thresh_we_i) begin
      thresh_d = thresh_wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mie_q    <= 1'b0;
      thresh_q <= '0;
      pend_q   <= '0;
      en_q     <= '0;
      prio_q   <= '0;
      vec_q    <= '0;
    end else begin
      mie_q    <= mie_d;
      thresh_q <= thresh_d;
      pend_q   <= pend_d;
      en_q     <= en_d;
      prio_q   <= prio_d;
      vec_q    <= vec_d;
    end
  end

  assign mie_o        = mie_q;
  assign thresh_o     = thresh_q;
  assign entry_pend_o = pend_q;
  assign entry_en_o   = en_q;
  assign entry_prio_o = prio_q;
  assign vec_addr_o   = vec_q;

  // the sequencer may only clear an entry that exists
  a_clear_id_range: assert property (@(posedge clk) disable iff (reset)
    clear_pend_valid_i |-> (int'(clear_pend_id_i) < VEC_NUM));

endmodule

/* logic/clic_pkg.sv */
// shared CSR map, operation and pc-select encodings, used by every CLIC block via scoped names
package clic_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] word_t;

  // csr instruction flavours, immediate forms are folded in by the core
  typedef enum logic [1:0] {
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_t;

  typedef enum logic {
    PC_NORMAL,
    PC_INTERRUPT
  } pc_sel_t;

  localparam csr_addr_t MSTATUS_ADDR     = 12'h300;
  localparam csr_addr_t INT_THRESH_ADDR  = 12'h347;
  localparam csr_addr_t STACK_DEPTH_ADDR = 12'h350;
  localparam csr_addr_t TIMER_COUNT_ADDR = 12'h400;
  localparam csr_addr_t TIMER_CMP_ADDR   = 12'h401;
  // one address per vector / entry, index added to the base
  localparam csr_addr_t VEC_BASE_ADDR    = 12'hb00;
  localparam csr_addr_t ENTRY_BASE_ADDR  = 12'hb40;

  localparam int MIE_BIT        = 3;
  localparam int ENTRY_PEND_BIT = 0;
  localparam int ENTRY_EN_BIT   = 1;

  // new register value for a csr op on the old value
  function automatic word_t csr_apply(word_t old_val, word_t wdata, csr_op_t op);
    case (op)
      CSR_RS:  return old_val | wdata;
      CSR_RC:  return old_val & ~wdata;
      default: return wdata;
    endcase
  endfunction

endpackage
